/* switch_settings.svh */
`ifndef SWITCH_SETTINGS_SVH
`define SWITCH_SETTINGS_SVH

// ****************************************
// Switch dimensions
// ****************************************

// Ingress ports, and egress ports
`define SW_PORTS 4

// Priority levels, 3 is the highest
`define SW_PRIOS 4

// Shared packet buffer geometry
`define SW_PAGE_WORDS 8
`define SW_PAGES 32
`define SW_WORD_W 16

`endif

/* buffer_pkg.sv */
`include "switch_settings.svh"

package buffer_pkg;

    // Page number in the shared buffer
    typedef logic [$clog2(`SW_PAGES)-1:0] page_id_t;

    // Word offset inside one page
    typedef logic [$clog2(`SW_PAGE_WORDS)-1:0] word_idx_t;

    // One data word as stored in the buffer
    typedef logic [`SW_WORD_W-1:0] word_t;

    // Arbiter requester number
    // 0 .. SW_PORTS-1 are ingress ports, the rest are egress ports
    typedef logic [$clog2(2 * `SW_PORTS)-1:0] peer_id_t;

endpackage

/* packet_pkg.sv */
`include "switch_settings.svh"

package packet_pkg;

    typedef logic [$clog2(`SW_PORTS)-1:0] port_id_t;
    typedef logic [$clog2(`SW_PRIOS)-1:0] prio_t;

    // Word count of a packet minus one
    typedef logic [$clog2(`SW_PAGE_WORDS)-1:0] pkt_len_t;

    // Header word layout
    localparam int HDR_DEST_LSB = 0;
    localparam int HDR_PRIO_LSB = 2;

    // One stored packet as seen by the egress queues
    typedef struct packed {
        buffer_pkg::page_id_t page;
        pkt_len_t             len;
        prio_t                prio;
    } pkt_desc_t;

    // Broadcast from the buffer to every egress port
    typedef struct packed {
        logic      vld;
        port_id_t  dest;
        pkt_desc_t desc;
    } join_t;

endpackage

/* buf_bus_if.sv */
interface buf_bus_if;
    import buffer_pkg::*;

    // Request side
    logic      req;
    logic      first;
    logic      last;
    logic      we;
    page_id_t  page;
    word_idx_t idx;
    word_t     wdata;

    // Arbiter side
    logic      grant;
    page_id_t  alloc_page;
    word_t     rdata;

    modport requester (
        output req, first, last, we, page, idx, wdata,
        input  grant, alloc_page, rdata
    );

    modport arbiter (
        input  req, first, last, we, page, idx, wdata,
        output grant, alloc_page, rdata
    );

endinterface

/* entry_fifo.sv */
module entry_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t head,
    output logic  empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty  = (count == '0);
    assign head   = mem[rd_ptr];
    assign do_pop = pop && !empty;
    // A full FIFO still takes a push when the head leaves in the same cycle
    assign do_push = push && ((count != CNT_W'(DEPTH)) || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* buffer_manager.sv */
`include "switch_settings.svh"

module buffer_manager (
    input  logic              clk,
    input  logic              rst_n,
    buf_bus_if.arbiter        peers [2 * `SW_PORTS],
    output packet_pkg::join_t join_bus,
    output logic              full
);
    import buffer_pkg::*;
    import packet_pkg::*;

    localparam int PEERS  = 2 * `SW_PORTS;
    localparam int FILL_W = $clog2(`SW_PAGES) + 1;

    logic [PEERS-1:0]  req_v;
    logic [PEERS-1:0]  first_v;
    logic [PEERS-1:0]  last_v;
    logic [PEERS-1:0]  we_v;
    page_id_t          page_v [PEERS];
    word_idx_t         idx_v [PEERS];
    word_t             wdata_v [PEERS];
    logic [PEERS-1:0]  eligible;
    peer_id_t          rr_ptr;
    peer_id_t          gnt_id;
    logic              gnt_vld;
    logic              sel_first;
    logic              sel_last;
    page_id_t          sel_page;
    word_idx_t         sel_idx;
    word_t             sel_wdata;
    page_id_t          wr_page;
    logic              wr_go;
    logic              rd_go;
    word_t             mem [`SW_PAGES * `SW_PAGE_WORDS];
    word_t             rdata_q;
    logic [FILL_W-1:0] fill_cnt;
    logic              filling;
    logic              alloc_ok;
    logic              free_push;
    page_id_t          free_item;
    page_id_t          free_head;
    logic              free_empty;
    port_id_t          hdr_dest [`SW_PORTS];
    prio_t             hdr_prio [`SW_PORTS];
    logic              join_vld_q;
    port_id_t          join_dest_q;
    pkt_desc_t         join_desc_q;

    // ****************************************
    // Round-robin arbiter over all peers
    // ****************************************
    assign alloc_ok = !filling && !free_empty;

    for (genvar i = 0; i < PEERS; i++) begin : g_peer
        assign req_v[i]            = peers[i].req;
        assign first_v[i]          = peers[i].first;
        assign last_v[i]           = peers[i].last;
        assign we_v[i]             = peers[i].we;
        assign page_v[i]           = peers[i].page;
        assign idx_v[i]            = peers[i].idx;
        assign wdata_v[i]          = peers[i].wdata;
        // New page wanted but none left, so hold the peer off
        assign eligible[i]         = req_v[i] && !(we_v[i] && first_v[i] && !alloc_ok);
        assign peers[i].grant      = gnt_vld && (gnt_id == peer_id_t'(i));
        assign peers[i].alloc_page = free_head;
        assign peers[i].rdata      = rdata_q;
    end

    always_comb begin
        peer_id_t cand;
        gnt_vld = 1'b0;
        gnt_id  = rr_ptr;
        for (int k = 0; k < PEERS; k++) begin
            cand = peer_id_t'(rr_ptr + k);
            if (!gnt_vld && eligible[cand]) begin
                gnt_vld = 1'b1;
                gnt_id  = cand;
            end
        end
    end

    assign sel_first = first_v[gnt_id];
    assign sel_last  = last_v[gnt_id];
    assign sel_page  = page_v[gnt_id];
    assign sel_idx   = idx_v[gnt_id];
    assign sel_wdata = wdata_v[gnt_id];
    assign wr_go     = gnt_vld && we_v[gnt_id];
    assign rd_go     = gnt_vld && !we_v[gnt_id];
    // Word 0 goes to the page that the free list hands out right now
    assign wr_page   = sel_first ? free_head : sel_page;

    // ****************************************
    // Packet memory
    // ****************************************
    always_ff @(posedge clk) begin
        if (wr_go) begin
            mem[{wr_page, sel_idx}] <= sel_wdata;
        end
        if (rd_go) begin
            rdata_q <= mem[{sel_page, sel_idx}];
        end
    end

    // Free list, loaded with every page after reset
    assign filling   = !fill_cnt[FILL_W-1];
    assign free_push = filling || (rd_go && sel_last);
    assign free_item = filling ? fill_cnt[FILL_W-2:0] : sel_page;

    entry_fifo #(
        .item_t (page_id_t),
        .DEPTH  (`SW_PAGES)
    ) u_free_list (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (free_push),
        .push_item (free_item),
        .pop       (wr_go && sel_first),
        .head      (free_head),
        .empty     (free_empty)
    );

    // Header fields per ingress port, needed again at the last word
    always_ff @(posedge clk) begin
        if (wr_go && sel_first) begin
            hdr_dest[port_id_t'(gnt_id)] <= sel_wdata[HDR_DEST_LSB +: $bits(port_id_t)];
            hdr_prio[port_id_t'(gnt_id)] <= sel_wdata[HDR_PRIO_LSB +: $bits(prio_t)];
        end
    end

    always_ff @(posedge clk) begin
        join_dest_q      <= sel_first ? sel_wdata[HDR_DEST_LSB +: $bits(port_id_t)]
                                      : hdr_dest[port_id_t'(gnt_id)];
        join_desc_q.prio <= sel_first ? sel_wdata[HDR_PRIO_LSB +: $bits(prio_t)]
                                      : hdr_prio[port_id_t'(gnt_id)];
        join_desc_q.page <= wr_page;
        join_desc_q.len  <= pkt_len_t'(sel_idx);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr     <= '0;
            fill_cnt   <= '0;
            full       <= 1'b1;
            join_vld_q <= 1'b0;
        end else begin
            if (gnt_vld) begin
                rr_ptr <= gnt_id + 1'b1;
            end
            if (filling) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            full       <= filling || free_empty;
            join_vld_q <= wr_go && sel_last;
        end
    end

    assign join_bus = '{vld: join_vld_q, dest: join_dest_q, desc: join_desc_q};

endmodule

/* ingress_port.sv */
`include "switch_settings.svh"

module ingress_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_sop,
    input  logic              wr_eop,
    input  logic              wr_vld,
    input  buffer_pkg::word_t wr_data,
    output logic              pause,
    buf_bus_if.requester      bus
);
    import buffer_pkg::*;

    localparam int CNT_W = $clog2(`SW_PAGE_WORDS) + 1;

    word_t            stage [`SW_PAGE_WORDS];
    logic [CNT_W-1:0] rx_cnt;
    logic [CNT_W-1:0] rx_base;
    logic [CNT_W-1:0] rx_next;
    logic             rx_room;
    logic             sending;
    word_idx_t        tx_idx;
    page_id_t         page_q;
    logic             tx_first;
    logic             tx_last;

    // ****************************************
    // Receive side
    // ****************************************

    // Start of packet restarts the word count
    assign rx_base = wr_sop ? '0 : rx_cnt;
    assign rx_room = !rx_base[CNT_W-1];
    assign rx_next = (wr_vld && rx_room) ? rx_base + 1'b1 : rx_base;

    always_ff @(posedge clk) begin
        if (!sending && wr_vld && rx_room) begin
            stage[rx_base[CNT_W-2:0]] <= wr_data;
        end
    end

    // ****************************************
    // Transmit side
    // ****************************************
    assign tx_first = (tx_idx == '0);
    assign tx_last  = (rx_cnt == {1'b0, tx_idx} + 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_cnt  <= '0;
            sending <= 1'b0;
            tx_idx  <= '0;
        end else if (!sending) begin
            rx_cnt <= rx_next;
            if (wr_eop && (rx_next != '0)) begin
                sending <= 1'b1;
            end
        end else if (bus.grant) begin
            if (tx_last) begin
                sending <= 1'b0;
                tx_idx  <= '0;
                rx_cnt  <= '0;
            end else begin
                tx_idx <= tx_idx + 1'b1;
            end
        end
    end

    // Page handed out with the grant of word 0
    always_ff @(posedge clk) begin
        if (bus.grant && tx_first) begin
            page_q <= bus.alloc_page;
        end
    end

    assign pause     = sending;
    assign bus.req   = sending;
    assign bus.we    = 1'b1;
    assign bus.first = tx_first;
    assign bus.last  = tx_last;
    assign bus.page  = page_q;
    assign bus.idx   = tx_idx;
    assign bus.wdata = stage[tx_idx];

endmodule

/* egress_port.sv */
`include "switch_settings.svh"

module egress_port #(
    parameter int PORT_ID = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  packet_pkg::join_t join_bus,
    input  logic              ready,
    output logic              rd_sop,
    output logic              rd_eop,
    output logic              rd_vld,
    output buffer_pkg::word_t rd_data,
    buf_bus_if.requester      bus
);
    import buffer_pkg::*;
    import packet_pkg::*;

    logic [`SW_PRIOS-1:0] q_push;
    logic [`SW_PRIOS-1:0] q_pop;
    logic [`SW_PRIOS-1:0] q_empty;
    pkt_desc_t            q_head [`SW_PRIOS];
    logic                 hit;
    prio_t                pick;
    logic                 start;
    logic                 busy;
    pkt_desc_t            cur;
    word_idx_t            rd_idx;
    logic                 rd_last;

    // ****************************************
    // Priority queues
    // ****************************************
    assign hit = join_bus.vld && (join_bus.dest == port_id_t'(PORT_ID));

    for (genvar p = 0; p < `SW_PRIOS; p++) begin : g_queue
        assign q_push[p] = hit && (join_bus.desc.prio == prio_t'(p));
        assign q_pop[p]  = start && (pick == prio_t'(p));

        // Deep enough for every page to sit in one queue
        entry_fifo #(
            .item_t (pkt_desc_t),
            .DEPTH  (`SW_PAGES)
        ) u_queue (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (q_push[p]),
            .push_item (join_bus.desc),
            .pop       (q_pop[p]),
            .head      (q_head[p]),
            .empty     (q_empty[p])
        );
    end

    // Strict priority, the highest non-empty queue wins
    always_comb begin
        pick = '0;
        for (int p = 0; p < `SW_PRIOS; p++) begin
            if (!q_empty[p]) begin
                pick = prio_t'(p);
            end
        end
    end

    // ready only matters when a packet is about to start
    assign start = !busy && ready && !(&q_empty);

    // ****************************************
    // Readout
    // ****************************************
    assign rd_last = (rd_idx == word_idx_t'(cur.len));

    always_ff @(posedge clk) begin
        if (start) begin
            cur <= q_head[pick];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rd_idx <= '0;
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            // Read data comes back one cycle after the grant
            rd_vld <= bus.grant;
            rd_sop <= bus.grant && (rd_idx == '0);
            rd_eop <= bus.grant && rd_last;
            if (start) begin
                busy   <= 1'b1;
                rd_idx <= '0;
            end else if (bus.grant) begin
                if (rd_last) begin
                    busy <= 1'b0;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    assign bus.req   = busy;
    assign bus.we    = 1'b0;
    assign bus.first = 1'b0;
    // Last read also returns the page to the free list
    assign bus.last  = rd_last;
    assign bus.page  = cur.page;
    assign bus.idx   = rd_idx;
    assign bus.wdata = '0;
    assign rd_data   = bus.rdata;

endmodule

/* switch_top.sv */
`include "switch_settings.svh"

module switch_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [`SW_PORTS-1:0]                  wr_sop,
    input  logic [`SW_PORTS-1:0]                  wr_eop,
    input  logic [`SW_PORTS-1:0]                  wr_vld,
    input  logic [`SW_PORTS-1:0][`SW_WORD_W-1:0]  wr_data,
    output logic [`SW_PORTS-1:0]                  pause,
    output logic                                  full,
    input  logic [`SW_PORTS-1:0]                  ready,
    output logic [`SW_PORTS-1:0]                  rd_sop,
    output logic [`SW_PORTS-1:0]                  rd_eop,
    output logic [`SW_PORTS-1:0]                  rd_vld,
    output logic [`SW_PORTS-1:0][`SW_WORD_W-1:0]  rd_data
);
    import packet_pkg::*;

    join_t join_bus;

    // Peers 0..3 are ingress ports, 4..7 egress ports
    buf_bus_if bus [2 * `SW_PORTS] ();

    buffer_manager u_buffer_manager (
        .clk      (clk),
        .rst_n    (rst_n),
        .peers    (bus),
        .join_bus (join_bus),
        .full     (full)
    );

    for (genvar i = 0; i < `SW_PORTS; i++) begin : g_port
        ingress_port u_ingress (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_sop  (wr_sop[i]),
            .wr_eop  (wr_eop[i]),
            .wr_vld  (wr_vld[i]),
            .wr_data (wr_data[i]),
            .pause   (pause[i]),
            .bus     (bus[i])
        );

        egress_port #(
            .PORT_ID (i)
        ) u_egress (
            .clk      (clk),
            .rst_n    (rst_n),
            .join_bus (join_bus),
            .ready    (ready[i]),
            .rd_sop   (rd_sop[i]),
            .rd_eop   (rd_eop[i]),
            .rd_vld   (rd_vld[i]),
            .rd_data  (rd_data[i]),
            .bus      (bus[`SW_PORTS + i])
        );
    end

endmodule

/* tb_scoreboard.sv */
`include "switch_settings.svh"

module tb_scoreboard (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic [`SW_PORTS-1:0]                 rd_sop,
    input logic [`SW_PORTS-1:0]                 rd_eop,
    input logic [`SW_PORTS-1:0]                 rd_vld,
    input logic [`SW_PORTS-1:0][`SW_WORD_W-1:0] rd_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import packet_pkg::*;

    typedef logic [`SW_PAGE_WORDS-1:0][`SW_WORD_W-1:0] page_words_t;

    typedef struct packed {
        pkt_len_t    len;
        page_words_t words;
    } exp_pkt_t;

    // One queue per destination and priority with index {dest, prio}
    exp_pkt_t             exp_q [`SW_PORTS * `SW_PRIOS][$];
    exp_pkt_t             cur [`SW_PORTS];
    pkt_len_t             word_i [`SW_PORTS];
    logic [`SW_PORTS-1:0] in_pkt = '0;
    int                   errors = 0;
    int                   sent = 0;
    int                   delivered = 0;

    // Routing from the header layout as {dest, prio}
    function automatic logic [3:0] expected_dest(input logic [`SW_WORD_W-1:0] header);
        port_id_t dest;
        prio_t    prio;
        dest = header[1:0];
        prio = header[3:2];
        return {dest, prio};
    endfunction

    task automatic push_expected(input logic [3:0] route, input page_words_t words,
                                 input pkt_len_t len);
        exp_pkt_t pkt;
        pkt.len   = len;
        pkt.words = words;
        exp_q[route].push_back(pkt);
        sent++;
    endtask

    function automatic bit drained();
        return (sent == delivered) && (in_pkt == '0);
    endfunction

    // Oldest waiting packet whose header bits 5..4 match the source
    function automatic int find_match(input logic [3:0] qi, input port_id_t src);
        for (int k = 0; k < exp_q[qi].size(); k++) begin
            if (exp_q[qi][k].words[0][5:4] == src) begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // ****************************************
    // Output checking at the falling edge
    // ****************************************
    always @(negedge clk) begin
        logic [3:0] qi;
        int         hit;
        if (rst_n) begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                if (!rd_vld[p]) begin
                    assert (!rd_sop[p] && !rd_eop[p]) else
                        note_error($sformatf("Port %0d raised sop or eop without rd_vld", p));
                end else begin
                    if (rd_sop[p]) begin
                        assert (!in_pkt[p]) else
                            note_error($sformatf("Port %0d started a packet inside another", p));
                        qi  = {port_id_t'(p), prio_t'(rd_data[p][3:2])};
                        hit = find_match(qi, port_id_t'(rd_data[p][5:4]));
                        assert (hit >= 0) else
                            note_error($sformatf(
                                "Port %0d delivered an unknown packet, header 0x%h",
                                p, rd_data[p]));
                        in_pkt[p] = (hit >= 0);
                        if (hit >= 0) begin
                            cur[p] = exp_q[qi][hit];
                            exp_q[qi].delete(hit);
                            word_i[p] = '0;
                            delivered++;
                        end
                    end
                    if (in_pkt[p]) begin
                        assert (rd_data[p] == cur[p].words[word_i[p]]) else
                            note_error($sformatf("[FAIL] rd_data[%0d] got 0x%h expected 0x%h",
                                                 p, rd_data[p], cur[p].words[word_i[p]]));
                        assert (rd_eop[p] == (word_i[p] == cur[p].len)) else
                            note_error($sformatf("[FAIL] rd_eop[%0d] got 0x%h expected 0x%h",
                                                 p, rd_eop[p], word_i[p] == cur[p].len));
                        if (word_i[p] == cur[p].len) begin
                            in_pkt[p] = 1'b0;
                        end else begin
                            word_i[p] = word_i[p] + 1'b1;
                        end
                    end else begin
                        assert (rd_sop[p]) else
                            note_error($sformatf("Port %0d delivered a word outside any packet",
                                                 p));
                    end
                end
            end
        end
    end

endmodule

/* tb_switch.sv */
`include "switch_settings.svh"

module tb_switch;
    timeunit 1ns;
    timeprecision 1ps;
    import packet_pkg::*;

    // Random traffic needs a few hundred cycles, all phases together stay far below this
    localparam int CYCLE_LIMIT = 20000;
    localparam int RANDOM_PKTS = 12;

    logic                                 clk = 1'b0;
    logic                                 rst_n;
    logic [`SW_PORTS-1:0]                 wr_sop;
    logic [`SW_PORTS-1:0]                 wr_eop;
    logic [`SW_PORTS-1:0]                 wr_vld;
    logic [`SW_PORTS-1:0][`SW_WORD_W-1:0] wr_data;
    logic [`SW_PORTS-1:0]                 pause;
    logic                                 full;
    logic [`SW_PORTS-1:0]                 ready;
    logic [`SW_PORTS-1:0]                 rd_sop;
    logic [`SW_PORTS-1:0]                 rd_eop;
    logic [`SW_PORTS-1:0]                 rd_vld;
    logic [`SW_PORTS-1:0][`SW_WORD_W-1:0] rd_data;
    int                                   errors = 0;
    int                                   cycle_cnt = 0;

    switch_top DUT (.*);

    tb_scoreboard u_sb (.*);

    always #5 clk = ~clk;

    task automatic log_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // Drives one packet, one word per cycle, starting on a rising edge
    task automatic drive_packet(input int port, input port_id_t dest, input prio_t prio,
                                input int nwords);
        logic [`SW_PAGE_WORDS-1:0][`SW_WORD_W-1:0] words;
        logic [3:0]                                route;
        words = '0;
        for (int i = 0; i < nwords; i++) begin
            words[i] = `SW_WORD_W'($urandom);
        end
        // Header: source, priority, destination
        words[0][5:0] = {port_id_t'(port), prio, dest};
        route = u_sb.expected_dest(words[0]);
        u_sb.push_expected(route, words, pkt_len_t'(nwords - 1));
        for (int i = 0; i < nwords; i++) begin
            wr_vld[port]  <= 1'b1;
            wr_sop[port]  <= (i == 0);
            wr_eop[port]  <= (i == nwords - 1);
            wr_data[port] <= words[i];
            @(posedge clk);
        end
        wr_vld[port] <= 1'b0;
        wr_sop[port] <= 1'b0;
        wr_eop[port] <= 1'b0;
    endtask

    // pause is up from the cycle after eop until the last word is stored
    task automatic wait_release(input int port);
        @(negedge clk);
        while (pause[port]) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic send_packet(input int port, input port_id_t dest, input prio_t prio,
                               input int nwords);
        drive_packet(port, dest, prio, nwords);
        wait_release(port);
    endtask

    task automatic random_stream(input int port, input int count);
        for (int n = 0; n < count; n++) begin
            send_packet(port, port_id_t'($urandom), prio_t'($urandom), 1 + int'($urandom % 8));
            repeat ($urandom % 3) @(posedge clk);
        end
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (!u_sb.drained()) @(posedge clk);
    endtask

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        int waited;
        void'($urandom(32'he1fe));
        rst_n   = 1'b0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        ready   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Idle state after reset, then the free list fill
        @(negedge clk);
        assert (rd_vld == '0 && rd_sop == '0 && rd_eop == '0) else
            log_error("Read strobes are active right after reset");
        assert (pause == '0) else log_error($sformatf("[FAIL] pause got 0x%h expected 0x0", pause));
        assert (full) else log_error($sformatf("[FAIL] full got 0x%h expected 0x1", full));
        waited = 0;
        while (full && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        assert (!full) else log_error("full is still high 40 cycles after reset");
        @(posedge clk);

        // Single packet, port 0 to port 2
        ready <= '1;
        send_packet(0, 2'd2, 2'd1, 5);
        wait_drained();

        // Strict priority while port 1 is held back
        ready[1] <= 1'b0;
        for (int pr = 0; pr < `SW_PRIOS; pr++) begin
            send_packet(0, 2'd1, prio_t'(pr), 3);
        end
        repeat (4) begin
            @(negedge clk);
            assert (!rd_vld[1]) else log_error("Port 1 sent data while ready was low");
        end
        @(posedge clk);
        ready[1] <= 1'b1;
        for (int k = `SW_PRIOS - 1; k >= 0; k--) begin
            @(negedge clk);
            while (!(rd_vld[1] && rd_sop[1])) @(negedge clk);
            assert (rd_data[1][3:2] == prio_t'(k)) else
                log_error($sformatf("[FAIL] rd_data[1] priority got 0x%h expected 0x%h",
                                    rd_data[1][3:2], prio_t'(k)));
        end
        wait_drained();

        // Random traffic on every port at once
        fork
            random_stream(0, RANDOM_PKTS);
            random_stream(1, RANDOM_PKTS);
            random_stream(2, RANDOM_PKTS);
            random_stream(3, RANDOM_PKTS);
        join
        wait_drained();

        // Fill every page, then one packet more
        ready <= '0;
        fork
            random_stream(0, 8);
            random_stream(1, 8);
            random_stream(2, 8);
            random_stream(3, 8);
        join
        repeat (2) @(negedge clk);
        assert (full) else log_error($sformatf("[FAIL] full got 0x%h expected 0x1", full));
        @(posedge clk);
        drive_packet(0, port_id_t'($urandom), prio_t'($urandom), 4);
        repeat (20) begin
            @(negedge clk);
            assert (pause[0]) else
                log_error($sformatf("[FAIL] pause[0] got 0x%h expected 0x1", pause[0]));
        end
        @(posedge clk);
        ready <= '1;
        wait_release(0);
        wait_drained();
        repeat (2) @(negedge clk);
        assert (!full) else log_error($sformatf("[FAIL] full got 0x%h expected 0x0", full));

        repeat (5) @(posedge clk);
        $display("Errors: %0d testbench, %0d scoreboard; packets sent %0d, delivered %0d",
                 errors, u_sb.errors, u_sb.sent, u_sb.delivered);
        if (errors == 0 && u_sb.errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Run limit
    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped by timeout after %0d cycles, %0d of %0d packets delivered",
                 cycle_cnt, u_sb.delivered, u_sb.sent);
        $display("Test failures found");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
buffer_pkg.sv
packet_pkg.sv
buf_bus_if.sv
entry_fifo.sv
buffer_manager.sv
ingress_port.sv
egress_port.sv
switch_top.sv
tb_scoreboard.sv
tb_switch.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_switch -o sim_switch

./obj_dir/sim_switch | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
